// File: src/mac_ctrl_config.svh
// MAC control build constants
`ifndef MAC_CTRL_CONFIG_SVH
`define MAC_CTRL_CONFIG_SVH

// Receive stream data width in bits.
`define MAC_DATA_W 64

// One byte enable per data byte.
`define MAC_KEEP_W 8

// A pause quantum is 512 bit times, which is 8 cycles on a 64-bit datapath.
`define MAC_QUANTA_CYCLES 8

// Width of each statistics counter.
`define MAC_STAT_W 16

`endif

// File: src/eth_frame_pkg.sv
// Ethernet frame field types
`default_nettype none

package eth_frame_pkg;

    // Station address, first transmitted byte in the top octet.
    typedef logic [47:0] mac_addr_t;

    // Length/type field of the Ethernet header.
    typedef logic [15:0] ethertype_t;

    // Reserved multicast address for MAC control frames, 01-80-C2-00-00-01.
    localparam mac_addr_t MCF_DST_MCAST = 48'h01_80_C2_00_00_01;

    // EtherType shared by all MAC control frames.
    localparam ethertype_t MCF_ETHERTYPE = 16'h8808;

endpackage

`default_nettype wire

// File: src/mac_ctrl_pkg.sv
// MAC control types
`default_nettype none
`include "mac_ctrl_config.svh"

package mac_ctrl_pkg;

    typedef logic [15:0] mcf_opcode_t;

    localparam mcf_opcode_t LFC_OPCODE = 16'h0001;  // 802.3 annex 31B PAUSE.

    typedef logic [15:0] pause_quanta_t;

    // Holds 65535 quanta of 8 cycles each.
    typedef logic [18:0] pause_timer_t;

    typedef struct packed {
        logic [`MAC_STAT_W-1:0] mcf;   // Accepted control frames.
        logic [`MAC_STAT_W-1:0] xon;
        logic [`MAC_STAT_W-1:0] xoff;
        logic [`MAC_STAT_W-1:0] bad;   // Frames flagged bad on their last beat.
    } mcf_stats_t;

endpackage

`default_nettype wire

// File: src/mcf_if.sv
// MAC control frame event bus
`timescale 1ns/1ps
`default_nettype none

interface mcf_if;

    logic                        valid;    // One-cycle pulse per accepted frame.
    eth_frame_pkg::mac_addr_t    eth_dst;
    eth_frame_pkg::mac_addr_t    eth_src;
    mac_ctrl_pkg::mcf_opcode_t   opcode;
    mac_ctrl_pkg::pause_quanta_t params;   // First parameter, the PAUSE quanta.

    modport src (
        output valid,
        output eth_dst,
        output eth_src,
        output opcode,
        output params
    );

    // Sinks have no way to stall, so they take the event in its valid cycle.
    modport snk (
        input valid,
        input eth_dst,
        input eth_src,
        input opcode,
        input params
    );

endinterface

`default_nettype wire

// File: src/mcf_parser.sv
// Control frame header parser
`timescale 1ns/1ps
`default_nettype none
`include "mac_ctrl_config.svh"

module mcf_parser (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`MAC_DATA_W-1:0] rx_tdata,
    input  wire logic [`MAC_KEEP_W-1:0] rx_tkeep,
    input  wire logic                   rx_tvalid,
    input  wire logic                   rx_tlast,
    input  wire logic                   rx_tuser,
    mcf_if.src                          mcf,
    output logic                        frame_bad
);

    logic [1:0] beat_idx;   // Index 3 means any beat past the header.

    eth_frame_pkg::mac_addr_t    hdr_dst;
    eth_frame_pkg::mac_addr_t    hdr_src;
    eth_frame_pkg::ethertype_t   hdr_type;
    mac_ctrl_pkg::mcf_opcode_t   hdr_opcode;
    mac_ctrl_pkg::pause_quanta_t hdr_params;

    logic last_q;     // The previous edge took a last beat.
    logic len_ok_q;
    logic err_q;
    logic hdr_match;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_idx <= 2'd0;
        end else if (rx_tvalid) begin
            if (rx_tlast) begin
                beat_idx <= 2'd0;
            end else if (beat_idx != 2'd3) begin
                beat_idx <= beat_idx + 2'd1;
            end
        end
    end

    // Byte 0 sits in the low lane, but multi-byte fields are big endian on the wire.
    always_ff @(posedge clk) begin
        if (rx_tvalid) begin
            case (beat_idx)
                2'd0: begin
                    hdr_dst <= {rx_tdata[7:0], rx_tdata[15:8], rx_tdata[23:16],
                                rx_tdata[31:24], rx_tdata[39:32], rx_tdata[47:40]};
                    hdr_src[47:32] <= {rx_tdata[55:48], rx_tdata[63:56]};
                end
                2'd1: begin
                    hdr_src[31:0] <= {rx_tdata[7:0], rx_tdata[15:8],
                                      rx_tdata[23:16], rx_tdata[31:24]};
                    hdr_type <= {rx_tdata[39:32], rx_tdata[47:40]};
                    hdr_opcode <= {rx_tdata[55:48], rx_tdata[63:56]};
                end
                2'd2: begin
                    hdr_params <= {rx_tdata[7:0], rx_tdata[15:8]};
                end
                default: ;
            endcase
        end
    end

    // A frame ending on beat 2 must still carry both quanta bytes.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= 1'b0;
            len_ok_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            last_q <= rx_tvalid && rx_tlast;
            if (rx_tvalid && rx_tlast) begin
                len_ok_q <= (beat_idx == 2'd3) || (beat_idx == 2'd2 && rx_tkeep[1]);
                err_q <= rx_tuser;
            end
        end
    end

    assign hdr_match = (hdr_dst == eth_frame_pkg::MCF_DST_MCAST) &&
                       (hdr_type == eth_frame_pkg::MCF_ETHERTYPE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcf.valid <= 1'b0;
            frame_bad <= 1'b0;
        end else begin
            mcf.valid <= last_q && len_ok_q && !err_q && hdr_match;
            frame_bad <= last_q && err_q;
        end
    end

    // Event fields are copied out so a back-to-back frame cannot disturb them.
    always_ff @(posedge clk) begin
        if (last_q) begin
            mcf.eth_dst <= hdr_dst;
            mcf.eth_src <= hdr_src;
            mcf.opcode <= hdr_opcode;
            mcf.params <= hdr_params;
        end
    end

endmodule

`default_nettype wire

// File: src/lfc_pause_timer.sv
// PAUSE quanta timer
`timescale 1ns/1ps
`default_nettype none
`include "mac_ctrl_config.svh"

module lfc_pause_timer (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic rx_lfc_en,
    mcf_if.snk        mcf,
    output wire logic rx_lfc_req,
    output logic      lfc_xon,
    output logic      lfc_xoff
);

    mac_ctrl_pkg::pause_timer_t pause_timer;   // Cycles of pause left.
    mac_ctrl_pkg::pause_timer_t pause_load;
    logic                       is_pause;

    assign is_pause = mcf.valid && (mcf.opcode == mac_ctrl_pkg::LFC_OPCODE);

    assign pause_load = mac_ctrl_pkg::pause_timer_t'(mcf.params) *
                        mac_ctrl_pkg::pause_timer_t'(`MAC_QUANTA_CYCLES);

    // A new PAUSE always reloads, so zero quanta ends a pause at once.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pause_timer <= '0;
        end else if (!rx_lfc_en) begin
            pause_timer <= '0;   // Disabling flow control releases the pause.
        end else if (is_pause) begin
            pause_timer <= pause_load;
        end else if (pause_timer != '0) begin
            pause_timer <= pause_timer - 1'b1;
        end
    end

    assign rx_lfc_req = (pause_timer != '0);

    // Frames are classified even when flow control is off.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfc_xon <= 1'b0;
            lfc_xoff <= 1'b0;
        end else begin
            lfc_xon <= is_pause && (mcf.params == '0);
            lfc_xoff <= is_pause && (mcf.params != '0);
        end
    end

endmodule

`default_nettype wire

// File: src/mcf_rx_stats.sv
// Receive control statistics
`timescale 1ns/1ps
`default_nettype none
`include "mac_ctrl_config.svh"

module mcf_rx_stats (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    mcf_if.snk                        mcf,
    input  wire logic                 lfc_xon,
    input  wire logic                 lfc_xoff,
    input  wire logic                 frame_bad,
    output mac_ctrl_pkg::mcf_stats_t  stats
);

    // Counters hold at all ones rather than wrap.
    function automatic logic [`MAC_STAT_W-1:0] sat_inc(
        input logic [`MAC_STAT_W-1:0] cnt,
        input logic                   hit
    );
        if (hit && (cnt != '1)) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stats <= '0;
        end else begin
            stats.mcf <= sat_inc(stats.mcf, mcf.valid);   // Every accepted opcode.
            stats.xon <= sat_inc(stats.xon, lfc_xon);
            stats.xoff <= sat_inc(stats.xoff, lfc_xoff);
            stats.bad <= sat_inc(stats.bad, frame_bad);
        end
    end

endmodule

`default_nettype wire

// File: src/mac_ctrl_rx.sv
// Receive MAC control top level
`timescale 1ns/1ps
`default_nettype none
`include "mac_ctrl_config.svh"

module mac_ctrl_rx (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`MAC_DATA_W-1:0] rx_tdata,
    input  wire logic [`MAC_KEEP_W-1:0] rx_tkeep,
    input  wire logic                   rx_tvalid,
    input  wire logic                   rx_tlast,
    input  wire logic                   rx_tuser,
    input  wire logic                   rx_lfc_en,
    output wire logic                   rx_lfc_req,
    output wire logic [`MAC_STAT_W-1:0] stat_rx_mcf,
    output wire logic [`MAC_STAT_W-1:0] stat_rx_lfc_xon,
    output wire logic [`MAC_STAT_W-1:0] stat_rx_lfc_xoff,
    output wire logic [`MAC_STAT_W-1:0] stat_rx_bad
);

    mcf_if mcf_bus ();

    wire logic                lfc_xon;
    wire logic                lfc_xoff;
    wire logic                frame_bad;
    mac_ctrl_pkg::mcf_stats_t stats;

    mcf_parser mcf_parser_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rx_tdata(rx_tdata),
        .rx_tkeep(rx_tkeep),
        .rx_tvalid(rx_tvalid),
        .rx_tlast(rx_tlast),
        .rx_tuser(rx_tuser),
        .mcf(mcf_bus.src),
        .frame_bad(frame_bad)
    );

    lfc_pause_timer lfc_pause_timer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rx_lfc_en(rx_lfc_en),
        .mcf(mcf_bus.snk),
        .rx_lfc_req(rx_lfc_req),
        .lfc_xon(lfc_xon),
        .lfc_xoff(lfc_xoff)
    );

    mcf_rx_stats mcf_rx_stats_inst (
        .clk(clk),
        .rst_n(rst_n),
        .mcf(mcf_bus.snk),
        .lfc_xon(lfc_xon),
        .lfc_xoff(lfc_xoff),
        .frame_bad(frame_bad),
        .stats(stats)
    );

    assign stat_rx_mcf = stats.mcf;
    assign stat_rx_lfc_xon = stats.xon;
    assign stat_rx_lfc_xoff = stats.xoff;
    assign stat_rx_bad = stats.bad;

endmodule

`default_nettype wire

// File: bench/tb_mac_ctrl_rx.sv
// Receive MAC control testbench
`timescale 1ns/1ps
`default_nettype none
`include "mac_ctrl_config.svh"

module tb_mac_ctrl_rx;

    localparam int DRAIN_LIMIT = 4000;   // Well above the longest pause in the stimulus.

    logic                        clk;
    logic                        rst_n;
    logic [`MAC_DATA_W-1:0]      rx_tdata;
    logic [`MAC_KEEP_W-1:0]      rx_tkeep;
    logic                        rx_tvalid;
    logic                        rx_tlast;
    logic                        rx_tuser;
    logic                        rx_lfc_en;
    wire logic                   rx_lfc_req;
    wire logic [`MAC_STAT_W-1:0] stat_rx_mcf;
    wire logic [`MAC_STAT_W-1:0] stat_rx_lfc_xon;
    wire logic [`MAC_STAT_W-1:0] stat_rx_lfc_xoff;
    wire logic [`MAC_STAT_W-1:0] stat_rx_bad;

    integer          seed;
    int              cyc = 0;         // Rising edges seen so far.
    int              exp_timer = 0;   // Expected pause cycles left.
    int              ev_edge[$];      // Edge at which each PAUSE frame loads the timer.
    int              ev_load[$];
    int              errors = 0;
    int              checks = 0;
    int              exp_mcf = 0;
    int              exp_xon = 0;
    int              exp_xoff = 0;
    int              exp_bad = 0;
    bit              checking = 1'b0;
    logic [8*24-1:0] cur_name = "reset";

    mac_ctrl_rx dut (
        .clk(clk),
        .rst_n(rst_n),
        .rx_tdata(rx_tdata),
        .rx_tkeep(rx_tkeep),
        .rx_tvalid(rx_tvalid),
        .rx_tlast(rx_tlast),
        .rx_tuser(rx_tuser),
        .rx_lfc_en(rx_lfc_en),
        .rx_lfc_req(rx_lfc_req),
        .stat_rx_mcf(stat_rx_mcf),
        .stat_rx_lfc_xon(stat_rx_lfc_xon),
        .stat_rx_lfc_xoff(stat_rx_lfc_xoff),
        .stat_rx_bad(stat_rx_bad)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Expected pause timer, stepped on the same edges as the DUT from testbench-driven inputs.
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!rst_n || !rx_lfc_en) begin
            exp_timer = 0;
        end else if (ev_edge.size() > 0 && ev_edge[0] == cyc) begin
            exp_timer = ev_load[0];   // Zero quanta ends the pause here.
        end else if (exp_timer > 0) begin
            exp_timer = exp_timer - 1;
        end
        if (ev_edge.size() > 0 && ev_edge[0] <= cyc) begin
            ev_edge.delete(0);
            ev_load.delete(0);
        end
    end

    always @(negedge clk) begin
        if (checking) begin
            checks++;
            if (rx_lfc_req !== (exp_timer != 0)) begin
                errors++;
                $display("CHECK FAILED %0s rx_lfc_req: expected %0b actual %0b at cycle %0d",
                         cur_name, exp_timer != 0, rx_lfc_req, cyc);
            end
        end
    end

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        rx_tvalid = 1'b0;
        rx_tlast = 1'b0;
        rx_tuser = 1'b0;
    endtask

    // Eight beats, byte 0 in the low lane, big-endian header fields, random payload.
    task automatic send_frame(input logic [47:0] dst, input logic [15:0] etype,
                              input logic [15:0] opcode, input logic [15:0] quanta,
                              input bit err, input bit en, input bit is_pause);
        logic [7:0]  bytes [0:63];
        logic [31:0] rnd;
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            bytes[i] = rnd[7:0];
        end
        for (int j = 0; j < 6; j++) begin
            bytes[j] = dst[47-8*j -: 8];
        end
        bytes[12] = etype[15:8];
        bytes[13] = etype[7:0];
        bytes[14] = opcode[15:8];
        bytes[15] = opcode[7:0];
        bytes[16] = quanta[15:8];
        bytes[17] = quanta[7:0];
        for (int b = 0; b < 8; b++) begin
            @(posedge clk);
            #2;
            for (int i = 0; i < 8; i++) begin
                rx_tdata[8*i +: 8] = bytes[8*b + i];
            end
            rx_tkeep = '1;
            rx_tvalid = 1'b1;
            rx_tlast = (b == 7);
            rx_tuser = err && (b == 7);   // The error flag only counts on the last beat.
            rx_lfc_en = en;
            if (b == 7 && is_pause) begin
                ev_edge.push_back(cyc + 3);   // Taken at the next edge, timer loads two later.
                ev_load.push_back(int'(quanta) * `MAC_QUANTA_CYCLES);
            end
        end
    endtask

    task automatic compare_stat(input logic [8*24-1:0] tag, input string field,
                                input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("CHECK FAILED %0s %0s: expected %0d actual %0d",
                     tag, field, expected, actual);
        end
    endtask

    task automatic check_stats(input logic [8*24-1:0] tag);
        compare_stat(tag, "stat_rx_mcf", int'(stat_rx_mcf), exp_mcf);
        compare_stat(tag, "stat_rx_lfc_xon", int'(stat_rx_lfc_xon), exp_xon);
        compare_stat(tag, "stat_rx_lfc_xoff", int'(stat_rx_lfc_xoff), exp_xoff);
        compare_stat(tag, "stat_rx_bad", int'(stat_rx_bad), exp_bad);
    endtask

    task automatic wait_pause_release(output bit ok);
        int cycles;
        cycles = 0;
        while (rx_lfc_req && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = !rx_lfc_req;
    endtask

    initial begin
        integer          fd;
        string           line;
        logic [8*24-1:0] name;
        logic [47:0]     dst;
        logic [15:0]     etype;
        logic [15:0]     opcode;
        logic [15:0]     quanta;
        int              err;
        int              en;
        int              gap;
        int              exp_ctrl;
        int              exp_pause;
        int              fields;
        bit              aborted;
        bit              ok;
        rst_n = 1'b0;
        rx_tdata = '0;
        rx_tkeep = '0;
        rx_tvalid = 1'b0;
        rx_tlast = 1'b0;
        rx_tuser = 1'b0;
        rx_lfc_en = 1'b0;
        seed = 32'h1702_6c5d;
        aborted = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        checking = 1'b1;
        fd = $fopen("bench/mac_ctrl_rx_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the stimulus file bench/mac_ctrl_rx_stim.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %d %d %d %d %d", name, dst, etype,
                             opcode, quanta, err, en, gap, exp_ctrl, exp_pause);
            if (fields != 10) begin
                $display("ERROR: stimulus line could not be parsed: %0s", line);
                errors++;
                continue;
            end
            cur_name = name;
            send_frame(dst, etype, opcode, quanta, err != 0, en != 0, exp_pause != 0);
            exp_mcf += exp_ctrl;
            exp_bad += err;
            if (exp_pause != 0 && quanta == 16'h0) begin
                exp_xon++;
            end else if (exp_pause != 0) begin
                exp_xoff++;
            end
            for (int g = 0; g < gap; g++) begin
                idle_cycle();
            end
            if (gap >= 4) begin   // Every counter has settled three edges after the last beat.
                @(negedge clk);
                check_stats(name);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!aborted) begin
            repeat (4) idle_cycle();
            wait_pause_release(ok);
            if (!ok) begin
                $display("ERROR: rx_lfc_req did not drop within %0d cycles", DRAIN_LIMIT);
                aborted = 1'b1;
            end else begin
                check_stats("final totals");
            end
        end
        checking = 1'b0;
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !aborted) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/mac_ctrl_rx_stim.txt
# columns: name dst ethertype opcode quanta err en gap exp_ctrl exp_pause
# dst, ethertype, opcode and quanta are hex; the rest are decimal, gap in idle cycles
xoff_q4         0180c2000001 8808 0001 0004 0 1 40 1 1
xoff_long       0180c2000001 8808 0001 0020 0 1 10 1 1
xon_release     0180c2000001 8808 0001 0000 0 1 12 1 1
xoff_q16        0180c2000001 8808 0001 0010 0 1 6 1 1
xoff_reload_q2  0180c2000001 8808 0001 0002 0 1 30 1 1
wrong_type      0180c2000001 8809 0001 0008 0 1 20 0 0
wrong_dst       0180c2000002 8808 0001 0008 0 1 20 0 0
errored_pause   0180c2000001 8808 0001 0008 1 1 20 0 0
other_opcode    0180c2000001 8808 0101 0008 0 1 20 1 0
xoff_disabled   0180c2000001 8808 0001 0006 0 0 20 1 1
xon_disabled    0180c2000001 8808 0001 0000 0 0 8 1 1
xoff_q12        0180c2000001 8808 0001 000c 0 1 6 1 1
disable_mid     0180c2000001 8809 0001 0000 0 0 10 0 0
b2b_xoff_q3     0180c2000001 8808 0001 0003 0 1 0 1 1
b2b_wrong_type  0180c2000001 0800 0001 0005 0 1 0 0 0
b2b_errored     0180c2000001 8808 0001 0009 1 1 0 0 0
b2b_xoff_q2     0180c2000001 8808 0001 0002 0 1 0 1 1
b2b_opcode2     0180c2000001 8808 0002 0000 0 1 40 1 0
final_xoff_q1   0180c2000001 8808 0001 0001 0 1 12 1 1

// File: files.f
+incdir+src
src/eth_frame_pkg.sv
src/mac_ctrl_pkg.sv
src/mcf_if.sv
src/mcf_parser.sv
src/lfc_pause_timer.sv
src/mcf_rx_stats.sv
src/mac_ctrl_rx.sv
bench/tb_mac_ctrl_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary -f files.f --top-module tb_mac_ctrl_rx -o tb_mac_ctrl_rx
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/tb_mac_ctrl_rx)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
